//--- design/mrd_buf_pkg.sv
package mrd_buf_pkg;

	// radix of the stage, one bank per digit value
	localparam int n_banks = 7;

	// row address inside a bank
	localparam int w_addr = 8;

	// sample width
	localparam int w_data = 16;

	// bank index, 0..6
	localparam int w_bank = 3;

	// accepted-sample counter, up to 7 * 256
	localparam int w_cnt = 11;

	// row count limits as held in the rows register
	localparam logic [w_addr:0] min_rows = 1;
	localparam logic [w_addr:0] max_rows = 1 << w_addr;

endpackage

//--- design/mrd_reg_pkg.sv
package mrd_reg_pkg;

	localparam int w_wb_data = 32;

	// frame sequencing states, also reported in reg_status
	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_sink   = 2'd1,
		st_drain  = 2'd2,
		st_source = 2'd3
	} ctrl_state_t;

	// word addresses on the wishbone side
	typedef enum logic [1:0] {
		reg_ctrl   = 2'd0,
		reg_rows   = 2'd1,
		reg_status = 2'd2
	} reg_addr_t;

	localparam int ctrl_en_bit      = 0;  // reg_ctrl
	localparam int status_state_lsb = 0;  // reg_status[1:0]
	localparam int status_frame_lsb = 8;  // reg_status[23:8]
	localparam int w_frame_cnt      = 16;

endpackage

//--- design/mrd_bank_ram.sv
module mrd_bank_ram
	import mrd_buf_pkg::*;
(
	input  logic              clk,
	input  logic              we,
	input  logic [w_addr-1:0] wr_addr,
	input  logic [w_data-1:0] wr_data,
	input  logic [w_addr-1:0] rd_addr,
	output logic [w_data-1:0] rd_data
);

	logic [w_data-1:0] mem [2**w_addr];

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// registered read, one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- design/mrd_fsm_sink.sv
module mrd_fsm_sink
	import mrd_buf_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               sink_en,
	input  logic [w_addr:0]    rows,
	input  logic               in_valid,
	input  logic [w_data-1:0]  in_data,
	output logic               in_ready,
	output logic [w_addr-1:0]  wr_addr,
	output logic [w_data-1:0]  wr_data,
	output logic [n_banks-1:0] wr_en,
	output logic               sink_done
);

	logic [w_bank-1:0] bank_pre;  // bank of the next sample
	logic [w_addr-1:0] row_pre;
	logic [w_cnt-1:0]  cnt;
	logic [w_cnt-1:0]  n_total;
	logic              accept;
	logic              wr_last;  // strobe of the final write in flight

	assign n_total  = w_cnt'(rows) * w_cnt'(n_banks);
	assign in_ready = sink_en && (cnt < n_total);
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!rst_n || !sink_en) begin
			bank_pre <= '0;
			row_pre  <= '0;
			cnt      <= '0;
		end else if (accept) begin
			cnt <= cnt + 1'b1;
			if (bank_pre == w_bank'(n_banks - 1)) begin
				bank_pre <= '0;
				row_pre  <= row_pre + 1'b1;  // next row after bank 6
			end else begin
				bank_pre <= bank_pre + 1'b1;
			end
		end
	end

	// write port registered one cycle behind the accept
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_en     <= '0;
			wr_last   <= 1'b0;
			sink_done <= 1'b0;
		end else begin
			wr_en     <= accept ? ({{(n_banks-1){1'b0}}, 1'b1} << bank_pre) : '0;
			wr_last   <= accept && (cnt == n_total - 1'b1);
			sink_done <= wr_last;
		end
	end

	always_ff @(posedge clk) begin
		wr_addr <= row_pre;
		wr_data <= in_data;
	end

	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr_en));

endmodule

//--- design/mrd_fsm_source.sv
module mrd_fsm_source
	import mrd_buf_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           source_start,
	input  logic [w_addr:0]                rows,
	input  logic [n_banks-1:0][w_data-1:0] rd_data_all,
	input  logic                           out_ready,
	output logic [w_addr-1:0]              rd_addr,
	output logic                           out_valid,
	output logic [w_data-1:0]              out_data,
	output logic                           out_last,
	output logic                           source_done
);

	logic              active;
	logic [w_bank-1:0] rd_bank;
	logic              row_end, issue_last, issue, pop;
	logic [2:0]        held;  // buffered plus in flight after this pop
	logic              pipe_valid, pipe_last;
	logic [w_bank-1:0] pipe_bank;
	logic [w_data-1:0] buf_data [2];
	logic              buf_last [2];
	logic              wr_ptr, rd_ptr;
	logic [1:0]        count;

	assign row_end    = ({1'b0, rd_addr} == rows - 1'b1);
	assign issue_last = row_end && (rd_bank == w_bank'(n_banks - 1));
	assign pop        = out_valid && out_ready;
	assign held       = 3'(count) + 3'(pipe_valid) - 3'(pop);
	assign issue      = (active || source_start) && (held < 3'd2);

	// bank-major walk over the rows of each bank
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active  <= 1'b0;
			rd_addr <= '0;
			rd_bank <= '0;
		end else if (issue && issue_last) begin
			active  <= 1'b0;
			rd_addr <= '0;
			rd_bank <= '0;
		end else begin
			if (source_start)
				active <= 1'b1;
			if (issue && row_end) begin
				rd_addr <= '0;
				rd_bank <= rd_bank + 1'b1;
			end else if (issue) begin
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pipe_valid <= 1'b0;
		else
			pipe_valid <= issue;
	end

	always_ff @(posedge clk) begin
		pipe_bank <= rd_bank;  // travels with the read
		pipe_last <= issue_last;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr ^ pipe_valid;
			rd_ptr <= rd_ptr ^ pop;
			count  <= count + 2'(pipe_valid) - 2'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (pipe_valid) begin
			buf_data[wr_ptr] <= rd_data_all[pipe_bank];
			buf_last[wr_ptr] <= pipe_last;
		end
	end

	assign out_valid   = (count != 2'd0);
	assign out_data    = buf_data[rd_ptr];
	assign out_last    = out_valid && buf_last[rd_ptr];
	assign source_done = pop && out_last;

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- design/mrd_ctrl_fsm.sv
module mrd_ctrl_fsm
	import mrd_reg_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic                   sink_done,
	input  logic                   source_done,
	output ctrl_state_t            state,
	output logic                   sink_en,
	output logic                   source_start,
	output logic [w_frame_cnt-1:0] frame_cnt
);

	ctrl_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
		st_idle:
			if (enable)
				state_nxt = st_sink;
		st_sink:
			if (sink_done)
				state_nxt = st_drain;
		st_drain:
			state_nxt = st_source;  // lets the last write land
		st_source:
			if (source_done)
				state_nxt = enable ? st_sink : st_idle;
		default:
			state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= st_idle;
			frame_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_source && source_done)
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	assign sink_en      = (state == st_sink);
	assign source_start = (state == st_drain);

	assert property (@(posedge clk) disable iff (!rst_n)
		source_start |-> (state == st_drain) ##1 (state == st_source));

	// sink only finishes while it is the active stage
	assert property (@(posedge clk) disable iff (!rst_n)
		sink_done |-> state == st_sink);

endmodule

//--- design/mrd_wb_regs.sv
module mrd_wb_regs
	import mrd_buf_pkg::*;
	import mrd_reg_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  reg_addr_t              wb_adr,
	input  logic [w_wb_data-1:0]   wb_dat_w,
	input  ctrl_state_t            state,
	input  logic [w_frame_cnt-1:0] frame_cnt,
	output logic [w_wb_data-1:0]   wb_dat_r,
	output logic                   wb_ack,
	output logic                   enable,
	output logic [w_addr:0]        rows
);

	logic                 req;
	logic [w_addr:0]      rows_wr;
	logic [w_wb_data-1:0] status;
	logic [w_wb_data-1:0] rd_word;

	assign req = wb_cyc && wb_stb && !wb_ack;

	always_comb begin
		if (wb_dat_w == '0)
			rows_wr = min_rows;  // 0 rows means 1
		else if (wb_dat_w > w_wb_data'(max_rows))
			rows_wr = max_rows;
		else
			rows_wr = wb_dat_w[w_addr:0];
	end

	always_comb begin
		status = '0;
		status[status_state_lsb +: 2]          = state;
		status[status_frame_lsb +: w_frame_cnt] = frame_cnt;
	end

	always_comb begin
		case (wb_adr)
		reg_ctrl:   rd_word = w_wb_data'(enable);
		reg_rows:   rd_word = w_wb_data'(rows);
		reg_status: rd_word = status;
		default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			enable <= 1'b0;
			rows   <= min_rows;
		end else begin
			wb_ack <= req;
			if (req && wb_we && wb_adr == reg_ctrl)
				enable <= wb_dat_w[ctrl_en_bit];
			if (req && wb_we && wb_adr == reg_rows)
				rows <= rows_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= rd_word;  // valid with ack
	end

	assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack);

endmodule

//--- design/mrd_reorder_top.sv
module mrd_reorder_top
	import mrd_buf_pkg::*;
	import mrd_reg_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  reg_addr_t            wb_adr,
	input  logic [w_wb_data-1:0] wb_dat_w,
	output logic [w_wb_data-1:0] wb_dat_r,
	output logic                 wb_ack,
	input  logic                 in_valid,
	input  logic [w_data-1:0]    in_data,
	output logic                 in_ready,
	output logic                 out_valid,
	output logic [w_data-1:0]    out_data,
	input  logic                 out_ready,
	output logic                 out_last
);

	logic                           enable;
	logic [w_addr:0]                rows;
	ctrl_state_t                    state;
	logic [w_frame_cnt-1:0]         frame_cnt;
	logic                           sink_en, sink_done;
	logic                           source_start, source_done;
	logic [w_addr-1:0]              wr_addr, rd_addr;
	logic [w_data-1:0]              wr_data;
	logic [n_banks-1:0]             wr_en;
	logic [n_banks-1:0][w_data-1:0] rd_data_all;

	mrd_wb_regs mrd_wb_regs_i (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.state(state), .frame_cnt(frame_cnt),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.enable(enable), .rows(rows)
	);

	mrd_ctrl_fsm mrd_ctrl_fsm_i (
		.clk(clk), .rst_n(rst_n),
		.enable(enable), .sink_done(sink_done), .source_done(source_done),
		.state(state), .sink_en(sink_en), .source_start(source_start),
		.frame_cnt(frame_cnt)
	);

	mrd_fsm_sink mrd_fsm_sink_i (
		.clk(clk), .rst_n(rst_n),
		.sink_en(sink_en), .rows(rows),
		.in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
		.wr_addr(wr_addr), .wr_data(wr_data), .wr_en(wr_en),
		.sink_done(sink_done)
	);

	// one bank per base-7 digit, shared write and read addresses
	for (genvar g = 0; g < n_banks; g++) begin : g_bank
		mrd_bank_ram mrd_bank_ram_i (
			.clk(clk),
			.we(wr_en[g]),
			.wr_addr(wr_addr),
			.wr_data(wr_data),
			.rd_addr(rd_addr),
			.rd_data(rd_data_all[g])
		);
	end

	mrd_fsm_source mrd_fsm_source_i (
		.clk(clk), .rst_n(rst_n),
		.source_start(source_start), .rows(rows),
		.rd_data_all(rd_data_all), .out_ready(out_ready),
		.rd_addr(rd_addr),
		.out_valid(out_valid), .out_data(out_data), .out_last(out_last),
		.source_done(source_done)
	);

endmodule

//--- tests/mrd_clk_gen.sv
module mrd_clk_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period  = 50;  // 100 ns clock
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// release lines up with the input drive point
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#10 rst_n = 1'b1;
	end

endmodule

//--- tests/mrd_reorder_tb.sv
module mrd_reorder_tb
	import mrd_buf_pkg::*;
	import mrd_reg_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int    drive_delay = 10;
	localparam string stim_file   = "tests/mrd_stimulus.txt";

	logic                 clk, rst_n;
	logic                 wb_cyc, wb_stb, wb_we, wb_ack;
	reg_addr_t            wb_adr;
	logic [w_wb_data-1:0] wb_dat_w, wb_dat_r;
	logic                 in_valid, in_ready;
	logic [w_data-1:0]    in_data, out_data;
	logic                 out_valid, out_ready, out_last;

	int                frame_rows[$];
	int                frame_mode[$];  // 0 steady, 1 random gaps
	logic [w_data-1:0] samples[$];
	logic [w_data-1:0] exp_q[$];
	int                cycle_limit = 0;

	mrd_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

	mrd_reorder_top mrd_reorder_top_i (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
		.out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
		.out_last(out_last)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_sample(input string name, input logic [w_data-1:0] want,
			input logic [w_data-1:0] got);
		if (got !== want)
			abort_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, want, got));
	endtask

	task automatic check_state(input string name, input ctrl_state_t want,
			input ctrl_state_t got);
		if (got !== want)
			abort_run($sformatf("mismatch at %0t: %s expected %s got %s",
				$time, name, want.name(), got.name()));
	endtask

	task automatic check_reg(input string name, input logic [w_wb_data-1:0] want,
			input logic [w_wb_data-1:0] got);
		if (got !== want)
			abort_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, want, got));
	endtask

	// drive point, a fixed delay after the rising edge
	task automatic next_slot();
		@(posedge clk);
		#(drive_delay);
	endtask

	function automatic bit next_token(input int fd, output string tok);
		string rest;
		int    n;
		n = $fscanf(fd, "%s", tok);
		while (n == 1 && tok.getc(0) == "#") begin
			n = $fgets(rest, fd);  // skip comment line
			n = $fscanf(fd, "%s", tok);
		end
		return n == 1;
	endfunction

	task automatic load_stimulus();
		int                fd, n, r, m, i;
		string             tok;
		logic [w_data-1:0] s;
		fd = $fopen(stim_file, "r");
		if (fd == 0)
			abort_run({"cannot open stimulus file ", stim_file});
		while (next_token(fd, tok)) begin
			n = $sscanf(tok, "%d", r);
			if (!next_token(fd, tok))
				abort_run("stimulus file ends inside a frame header");
			n = $sscanf(tok, "%d", m);
			if (r < 1 || r > 256)
				abort_run($sformatf("row count %0d in stimulus file is out of range", r));
			frame_rows.push_back(r);
			frame_mode.push_back(m);
			for (i = 0; i < n_banks * r; i++) begin
				if (!next_token(fd, tok))
					abort_run("stimulus file ends inside a frame");
				n = $sscanf(tok, "%h", s);
				samples.push_back(s);
			end
		end
		$fclose(fd);
	endtask

	task automatic bus_access(input logic we, input reg_addr_t adr,
			input logic [w_wb_data-1:0] wdata, output logic [w_wb_data-1:0] rdata);
		next_slot();
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		next_slot();
		#1;
		if (wb_ack !== 1'b1)
			abort_run("wb_ack did not rise in the cycle after the request");
		rdata = wb_dat_r;
		next_slot();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		#1;
		if (wb_ack !== 1'b0)
			abort_run("wb_ack stayed high for a second cycle");
	endtask

	task automatic write_reg(input reg_addr_t adr, input logic [w_wb_data-1:0] data);
		logic [w_wb_data-1:0] unused;
		bus_access(1'b1, adr, data, unused);
	endtask

	task automatic read_reg(input reg_addr_t adr, output logic [w_wb_data-1:0] data);
		bus_access(1'b0, adr, '0, data);
	endtask

	task automatic feed_frame(input int base, input int n, input bit gaps);
		int i;
		i = 0;
		while (i < n) begin
			next_slot();
			in_valid = gaps ? ($urandom % 3 != 0) : 1'b1;
			in_data  = samples[base + i];
			#1;
			if (in_valid && in_ready)
				i++;
		end
		next_slot();
		in_valid = 1'b0;
	endtask

	task automatic collect_frame(input int n, input bit gaps);
		int                k;
		logic [w_data-1:0] want;
		k = 0;
		while (k < n) begin
			next_slot();
			out_ready = gaps ? ($urandom % 2 == 0) : 1'b1;
			#1;
			if (out_valid && out_ready) begin
				want = exp_q.pop_front();
				check_sample("out_data", want, out_data);
				if (out_last !== (k == n - 1))
					abort_run($sformatf("out_last wrong on output %0d of %0d", k + 1, n));
				k++;
			end
		end
		next_slot();
		#1;
		if (out_valid)
			abort_run("extra output sample after out_last");
	endtask

	task automatic run_frame(input int f, input int base);
		int                   r, n, k;
		bit                   gaps, last;
		logic [w_wb_data-1:0] rd;
		r    = frame_rows[f];
		n    = n_banks * r;
		gaps = (frame_mode[f] != 0);
		last = (f == frame_rows.size() - 1);
		exp_q.delete();
		for (k = 0; k < n; k++)
			exp_q.push_back(samples[base + (k % r) * n_banks + k / r]);  // base-7 digit swap
		write_reg(reg_rows, 32'(r));
		if (f == 0)
			write_reg(reg_ctrl, 32'd1);
		fork
			begin
				feed_frame(base, n, gaps);
				if (last)
					write_reg(reg_ctrl, 32'd0);  // lands mid-frame, honored at the end
			end
			collect_frame(n, gaps);
		join
		read_reg(reg_status, rd);
		check_state("status.state", last ? st_idle : st_sink, ctrl_state_t'(rd[1:0]));
		check_reg("status.frame_cnt", 32'(f + 1), 32'(rd[23:8]));
		if (last) begin
			repeat (8) begin
				next_slot();
				#1;
				if (in_ready !== 1'b0)
					abort_run("in_ready high after enable was cleared");
			end
		end
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		abort_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
	end

	initial begin
		logic [w_wb_data-1:0] rd;
		int                   base, f;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = reg_ctrl;
		wb_dat_w  = '0;
		in_valid  = 1'b0;
		in_data   = '0;
		out_ready = 1'b0;
		void'($urandom(48120));
		load_stimulus();
		cycle_limit = 20 * samples.size() + 2000;
		wait (rst_n === 1'b1);

		write_reg(reg_rows, 32'd37);
		read_reg(reg_rows, rd);
		check_reg("reg_rows", 32'd37, rd);
		write_reg(reg_rows, 32'd0);
		read_reg(reg_rows, rd);
		check_reg("reg_rows", 32'd1, rd);  // zero rows clamps to one
		read_reg(reg_status, rd);
		check_state("status.state", st_idle, ctrl_state_t'(rd[1:0]));

		base = 0;
		for (f = 0; f < frame_rows.size(); f++) begin
			run_frame(f, base);
			base += n_banks * frame_rows[f];
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- tests/mrd_stimulus.txt
# frame header: rows (decimal) and mode (0 steady, 1 random in_valid and out_ready gaps)
# then 7*rows input samples in hex, in arrival order
1 0
f00d 0001 7fff 8000 1234 abcd 0f0f
4 0
2000 2001 2002 2003 2004 2005 2006 2007 2008 2009 200a 200b 200c 200d 200e 200f
2010 2011 2012 2013 2014 2015 2016 2017 2018 2019 201a 201b
37 0
3000 3001 3002 3003 3004 3005 3006 3007 3008 3009 300a 300b 300c 300d 300e 300f
3010 3011 3012 3013 3014 3015 3016 3017 3018 3019 301a 301b 301c 301d 301e 301f
3020 3021 3022 3023 3024 3025 3026 3027 3028 3029 302a 302b 302c 302d 302e 302f
3030 3031 3032 3033 3034 3035 3036 3037 3038 3039 303a 303b 303c 303d 303e 303f
3040 3041 3042 3043 3044 3045 3046 3047 3048 3049 304a 304b 304c 304d 304e 304f
3050 3051 3052 3053 3054 3055 3056 3057 3058 3059 305a 305b 305c 305d 305e 305f
3060 3061 3062 3063 3064 3065 3066 3067 3068 3069 306a 306b 306c 306d 306e 306f
3070 3071 3072 3073 3074 3075 3076 3077 3078 3079 307a 307b 307c 307d 307e 307f
3080 3081 3082 3083 3084 3085 3086 3087 3088 3089 308a 308b 308c 308d 308e 308f
3090 3091 3092 3093 3094 3095 3096 3097 3098 3099 309a 309b 309c 309d 309e 309f
30a0 30a1 30a2 30a3 30a4 30a5 30a6 30a7 30a8 30a9 30aa 30ab 30ac 30ad 30ae 30af
30b0 30b1 30b2 30b3 30b4 30b5 30b6 30b7 30b8 30b9 30ba 30bb 30bc 30bd 30be 30bf
30c0 30c1 30c2 30c3 30c4 30c5 30c6 30c7 30c8 30c9 30ca 30cb 30cc 30cd 30ce 30cf
30d0 30d1 30d2 30d3 30d4 30d5 30d6 30d7 30d8 30d9 30da 30db 30dc 30dd 30de 30df
30e0 30e1 30e2 30e3 30e4 30e5 30e6 30e7 30e8 30e9 30ea 30eb 30ec 30ed 30ee 30ef
30f0 30f1 30f2 30f3 30f4 30f5 30f6 30f7 30f8 30f9 30fa 30fb 30fc 30fd 30fe 30ff
3100 3101 3102
4 1
5500 5501 5502 5503 5504 5505 5506 5507 5508 5509 550a 550b 550c 550d 550e 550f
5510 5511 5512 5513 5514 5515 5516 5517 5518 5519 551a 551b
6 1
6100 6101 6102 6103 6104 6105 6106 6107 6108 6109 610a 610b 610c 610d 610e 610f
6110 6111 6112 6113 6114 6115 6116 6117 6118 6119 611a 611b 611c 611d 611e 611f
6120 6121 6122 6123 6124 6125 6126 6127 6128 6129

//--- flist.f
design/mrd_buf_pkg.sv
design/mrd_reg_pkg.sv
design/mrd_bank_ram.sv
design/mrd_fsm_sink.sv
design/mrd_fsm_source.sv
design/mrd_ctrl_fsm.sv
design/mrd_wb_regs.sv
design/mrd_reorder_top.sv
tests/mrd_clk_gen.sv
tests/mrd_reorder_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mrd_reorder_tb
RTL_TOP   ?= mrd_reorder_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

run: $(SIM)
	./$(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
